/* logic/sram_defines.svh */
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// memory geometry
`define WORD_W 16
`define ADDR_W 11

// locations covered by one fill and check run
`define FILL_COUNT 128

// step period exponents, selected by speed
`define STEP_SHIFT0 2
`define STEP_SHIFT1 3
`define STEP_SHIFT2 4
`define STEP_SHIFT3 5

// mismatch counter width
`define ERR_W 8

`endif

/* logic/memPkg.sv */
`include "sram_defines.svh"
`default_nettype none

package memPkg;

	// one data word
	typedef logic [`WORD_W-1:0] memWordT;

	// one word address
	typedef logic [`ADDR_W-1:0] memAddrT;

	// single access request, strobes are one cycle wide
	typedef struct packed {
		logic write;
		logic read;
		memAddrT addr;
		memWordT data;
	} memCmdT;

	// read result, valid for one cycle
	typedef struct packed {
		logic valid;
		memWordT data;
	} memRspT;

endpackage

`default_nettype wire

/* logic/seqPkg.sv */
`include "sram_defines.svh"
`default_nettype none

package seqPkg;

	// sequencer phase
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		CHECK,
		DONE
	} seqPhaseT;

	// run mode, check only skips the fill
	typedef enum logic {
		FILL_CHECK,
		CHECK_ONLY
	} seqModeT;

	// status seen by the host
	typedef struct packed {
		seqPhaseT phase;
		logic busy;
		logic done;
		logic [`ERR_W-1:0] errorCount;
	} seqStatusT;

endpackage

`default_nettype wire

/* logic/sramArray.sv */
`include "sram_defines.svh"
`default_nettype none

module sramArray #(
	parameter type wordT = memPkg::memWordT,
	parameter int DEPTH = 1 << `ADDR_W
) (
	input wire CLK,
	input wire we,
	input wire re,
	input wire memPkg::memAddrT addr,
	input wire wordT wrData,
	output wordT rdData
);

	// word storage
	wordT mem [DEPTH];

	// write port
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wrData;
		end
	end

	// registered read, holds the last word between reads
	always_ff @(posedge CLK) begin
		if (re) begin
			rdData <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* logic/memAddrReg.sv */
`default_nettype none

module memAddrReg (
	input wire CLK,
	input wire rst,
	input wire memPkg::memCmdT cmd,
	output memPkg::memAddrT addr,
	output logic we,
	output logic re
);

	// enables follow the command strobes
	always_ff @(posedge CLK) begin
		if (!rst) begin
			we <= 1'b0;
			re <= 1'b0;
		end else begin
			we <= cmd.write;
			re <= cmd.read;
		end
	end

	// address only loads on an access, otherwise held
	always_ff @(posedge CLK) begin
		if (cmd.write || cmd.read) begin
			addr <= cmd.addr;
		end
	end

endmodule

`default_nettype wire

/* logic/memDataReg.sv */
`default_nettype none

module memDataReg #(
	parameter type wordT = memPkg::memWordT
) (
	input wire CLK,
	input wire rst,
	input wire memPkg::memCmdT cmd,
	output wordT wrData,
	input wire wordT rdData,
	output memPkg::memRspT rsp
);

	// read accepted with the command
	logic readReq;
	// memory is loading its output register
	logic readPend;

	// write data loads with a write command
	always_ff @(posedge CLK) begin
		if (cmd.write) begin
			wrData <= cmd.data;
		end
	end

	// read tracking, lines up with the memory read latency
	always_ff @(posedge CLK) begin
		if (!rst) begin
			readReq <= 1'b0;
			readPend <= 1'b0;
			rsp.valid <= 1'b0;
		end else begin
			readReq <= cmd.read;
			readPend <= readReq;
			rsp.valid <= readPend;
		end
	end

	// capture the read word once it is out of the array
	always_ff @(posedge CLK) begin
		if (readPend) begin
			rsp.data <= rdData;
		end
	end

endmodule

`default_nettype wire

/* logic/stepTimer.sv */
`include "sram_defines.svh"
`default_nettype none

module stepTimer (
	input wire CLK,
	input wire rst,
	input wire [1:0] speed,
	output logic step
);

	// counter wide enough for the slowest rate
	localparam int CntW = `STEP_SHIFT3;

	logic [CntW-1:0] count;
	logic [CntW-1:0] countNext;
	logic [CntW-1:0] mask;

	always_comb begin
		countNext = count + 1'b1;
		// low bits that must be zero for a step
		case (speed)
			2'd0: mask = CntW'((1 << `STEP_SHIFT0) - 1);
			2'd1: mask = CntW'((1 << `STEP_SHIFT1) - 1);
			2'd2: mask = CntW'((1 << `STEP_SHIFT2) - 1);
			default: mask = CntW'((1 << `STEP_SHIFT3) - 1);
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst) begin
			count <= '0;
			step <= 1'b0;
		end else begin
			count <= countNext;
			// one cycle strobe when the masked bits wrap
			step <= (countNext & mask) == '0;
		end
	end

endmodule

`default_nettype wire

/* logic/fillCheckSeq.sv */
`include "sram_defines.svh"
`default_nettype none

module fillCheckSeq (
	input wire CLK,
	input wire rst,
	input wire start,
	input wire seqPkg::seqModeT mode,
	input wire step,
	input wire memPkg::memCmdT hostCmd,
	input wire memPkg::memRspT rdRsp,
	output memPkg::memCmdT cmd,
	output seqPkg::seqStatusT status
);

	localparam memPkg::memAddrT LastAddr = memPkg::memAddrT'(`FILL_COUNT - 1);

	seqPkg::seqPhaseT phase;
	// next address to write or read
	memPkg::memAddrT issueAddr;
	// address of the next response, responses come back in order
	memPkg::memAddrT cmpAddr;
	logic [`ERR_W-1:0] errorCount;
	logic busy;
	logic issueRead;

	// descending pattern, address a holds FILL_COUNT - 1 - a
	function automatic memPkg::memWordT patternWord(input memPkg::memAddrT a);
		return memPkg::memWordT'(`FILL_COUNT - 1) - memPkg::memWordT'(a);
	endfunction

	assign busy = (phase == seqPkg::FILL) || (phase == seqPkg::CHECK);
	assign issueRead = step && (phase == seqPkg::CHECK) && (issueAddr < `FILL_COUNT);

	always_comb begin
		status.phase = phase;
		status.busy = busy;
		status.done = (phase == seqPkg::DONE);
		status.errorCount = errorCount;
	end

	// phase control, counters and error count
	always_ff @(posedge CLK) begin
		if (!rst) begin
			phase <= seqPkg::IDLE;
			issueAddr <= '0;
			cmpAddr <= '0;
			errorCount <= '0;
		end else begin
			case (phase)
				seqPkg::FILL: begin
					if (step) begin
						if (issueAddr == LastAddr) begin
							phase <= seqPkg::CHECK;
							issueAddr <= '0;
						end else begin
							issueAddr <= issueAddr + 1'b1;
						end
					end
				end
				seqPkg::CHECK: begin
					if (issueRead) begin
						issueAddr <= issueAddr + 1'b1;
					end
					if (rdRsp.valid) begin
						// saturate rather than wrap
						if (rdRsp.data != patternWord(cmpAddr) && errorCount != '1) begin
							errorCount <= errorCount + 1'b1;
						end
						if (cmpAddr == LastAddr) begin
							phase <= seqPkg::DONE;
						end else begin
							cmpAddr <= cmpAddr + 1'b1;
						end
					end
				end
				default: begin
					// idle or done, a new run may start
					if (start) begin
						if (mode == seqPkg::CHECK_ONLY) begin
							phase <= seqPkg::CHECK;
						end else begin
							phase <= seqPkg::FILL;
						end
						issueAddr <= '0;
						cmpAddr <= '0;
						errorCount <= '0;
					end
				end
			endcase
		end
	end

	// command register, host owns the port while not busy
	always_ff @(posedge CLK) begin
		if (busy) begin
			cmd.addr <= issueAddr;
			cmd.data <= patternWord(issueAddr);
		end else begin
			cmd.addr <= hostCmd.addr;
			cmd.data <= hostCmd.data;
		end
		if (!rst) begin
			cmd.write <= 1'b0;
			cmd.read <= 1'b0;
		end else if (busy) begin
			cmd.write <= step && (phase == seqPkg::FILL);
			cmd.read <= issueRead;
		end else begin
			cmd.write <= hostCmd.write;
			cmd.read <= hostCmd.read;
		end
	end

endmodule

`default_nettype wire

/* logic/sramSubsystem.sv */
`include "sram_defines.svh"
`default_nettype none

module sramSubsystem (
	input wire CLK,
	input wire rst,
	input wire start,
	input wire seqPkg::seqModeT mode,
	input wire [1:0] speed,
	input wire memPkg::memCmdT hostCmd,
	output memPkg::memRspT readRsp,
	output seqPkg::seqStatusT status
);

	logic step;
	// registered command from the sequencer
	memPkg::memCmdT seqCmd;
	// MAR outputs
	memPkg::memAddrT marAddr;
	logic marWe;
	logic marRe;
	// data between MDR and array
	memPkg::memWordT mdrWrData;
	memPkg::memWordT sramRdData;

	stepTimer uStepTimer (
		.CLK(CLK),
		.rst(rst),
		.speed(speed),
		.step(step)
	);

	fillCheckSeq uSeq (
		.CLK(CLK),
		.rst(rst),
		.start(start),
		.mode(mode),
		.step(step),
		.hostCmd(hostCmd),
		.rdRsp(readRsp),
		.cmd(seqCmd),
		.status(status)
	);

	memAddrReg uMar (
		.CLK(CLK),
		.rst(rst),
		.cmd(seqCmd),
		.addr(marAddr),
		.we(marWe),
		.re(marRe)
	);

	memDataReg #(.wordT(memPkg::memWordT)) uMdr (
		.CLK(CLK),
		.rst(rst),
		.cmd(seqCmd),
		.wrData(mdrWrData),
		.rdData(sramRdData),
		.rsp(readRsp)
	);

	sramArray #(.wordT(memPkg::memWordT), .DEPTH(1 << `ADDR_W)) uSram (
		.CLK(CLK),
		.we(marWe),
		.re(marRe),
		.addr(marAddr),
		.wrData(mdrWrData),
		.rdData(sramRdData)
	);

endmodule

`default_nettype wire

/* verif/sramSubsystem_chk.sv */
`default_nettype none

module sramSubsystemChk (
	input wire CLK,
	input wire rst,
	input wire start,
	input wire step,
	input wire memPkg::memCmdT seqCmd,
	input wire memPkg::memRspT readRsp,
	input wire seqPkg::seqStatusT status
);
	timeunit 1ns;
	timeprecision 100ps;

	// a reset cycle leaves the sequencer idle
	resetIdle: assert property (@(posedge CLK) !rst |=> !status.busy)
		else $error("busy high after a reset cycle");

	// phase only moves on a step or a response, never on start while busy
	startIgnored: assert property (@(posedge CLK) disable iff (!rst)
		start && status.busy && !step && !readRsp.valid |=> $stable(status.phase))
		else $error("start changed the phase of a running test");

	// MAR, memory and MDR stages
	readLatency: assert property (@(posedge CLK) disable iff (!rst)
		$past(rst, 3) |-> readRsp.valid == $past(seqCmd.read, 3))
		else $error("read response not three cycles after the registered read");

	// done is a level up to the next start, and never with busy
	doneHolds: assert property (@(posedge CLK) disable iff (!rst)
		status.done && !start |=> status.done && !status.busy)
		else $error("done dropped or busy rose without a start");

endmodule

bind sramSubsystem sramSubsystemChk uChk (
	.CLK(CLK),
	.rst(rst),
	.start(start),
	.step(step),
	.seqCmd(seqCmd),
	.readRsp(readRsp),
	.status(status)
);

`default_nettype wire

/* verif/sramSubsystemTb.sv */
`include "sram_defines.svh"
`default_nettype none

module sramSubsystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	// each run takes at most 2 * FILL_COUNT steps of 8 cycles, so this leaves wide margin
	localparam int TimeoutCycles = 40000;

	typedef struct packed {
		memPkg::memAddrT addr;
		memPkg::memWordT data;
		int cycle;
	} expReadT;

	logic CLK = 1'b0;
	logic rst;
	logic start;
	seqPkg::seqModeT mode;
	logic [1:0] speed;
	memPkg::memCmdT hostCmd;
	memPkg::memRspT readRsp;
	seqPkg::seqStatusT status;

	// memory model, host written words and tested locations that differ from the pattern
	memPkg::memWordT shadow [1 << `ADDR_W];
	bit corrupted [1 << `ADDR_W];
	expReadT expQ [$];
	memPkg::memAddrT badAddr [3];
	memPkg::memWordT badData;
	memPkg::memAddrT hiAddr;
	memPkg::memWordT hiData;
	int seed = 40901;
	int cycles = 0;
	int errors = 0;
	int checks = 0;

	sramSubsystem uut (.CLK, .rst, .start, .mode, .speed, .hostCmd, .readRsp, .status);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("timeout after %0d cycles, test did not finish, errors %0d", cycles, errors);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic memPkg::memWordT expectedWord(input memPkg::memAddrT addr);
		if (addr < `FILL_COUNT && !corrupted[addr]) begin
			return memPkg::memWordT'(`FILL_COUNT - 1 - int'(addr));
		end
		return shadow[addr];
	endfunction

	function automatic int expectedErrors(input seqPkg::seqModeT runMode);
		int n = 0;
		if (runMode == seqPkg::CHECK_ONLY) begin
			for (int a = 0; a < `FILL_COUNT; a++) begin
				n += int'(corrupted[a]);
			end
		end
		// counter saturates
		return (n > (1 << `ERR_W) - 1) ? (1 << `ERR_W) - 1 : n;
	endfunction

	function automatic memPkg::memAddrT randomAddr(input int lo, input int span);
		return memPkg::memAddrT'(lo + ($unsigned($random(seed)) % span));
	endfunction

	function automatic memPkg::memWordT randomWord();
		return memPkg::memWordT'($random(seed));
	endfunction

	task automatic expectValue(input string name, input int got, input int want);
		checks++;
		assert (got == want) else begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	// one cycle host strobe, model follows only when the DUT should honor it
	task automatic hostAccess(input logic wr, input memPkg::memAddrT addr,
			input memPkg::memWordT data, input bit honored);
		expReadT e;
		hostCmd.write = wr;
		hostCmd.read = !wr;
		hostCmd.addr = addr;
		hostCmd.data = data;
		if (honored && wr) begin
			shadow[addr] = data;
			if (addr < `FILL_COUNT) begin
				corrupted[addr] = 1'b1;
			end
		end else if (honored) begin
			e.addr = addr;
			e.data = expectedWord(addr);
			e.cycle = cycles;
			expQ.push_back(e);
		end
		@(negedge CLK);
		hostCmd.write = 1'b0;
		hostCmd.read = 1'b0;
	endtask

	task automatic drainReads();
		while (expQ.size() != 0) begin
			@(negedge CLK);
		end
	endtask

	task automatic startRun(input seqPkg::seqModeT runMode, input logic [1:0] runSpeed);
		drainReads();
		mode = runMode;
		speed = runSpeed;
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		expectValue("status.busy", int'(status.busy), 1);
	endtask

	task automatic finishRun(input seqPkg::seqModeT runMode);
		int want;
		want = expectedErrors(runMode);
		while (!status.done) begin
			@(negedge CLK);
		end
		expectValue("status.errorCount", int'(status.errorCount), want);
		expectValue("status.busy", int'(status.busy), 0);
		if (runMode == seqPkg::FILL_CHECK) begin
			for (int a = 0; a < `FILL_COUNT; a++) begin
				corrupted[a] = 1'b0;
			end
		end
	endtask

	// host read responses only, sequencer reads come back while busy
	always @(negedge CLK) begin : compareReads
		expReadT e;
		if (rst && readRsp.valid && !status.busy) begin
			assert (expQ.size() != 0) else begin
				$display("read response arrived with no host read outstanding");
				errors++;
			end
			if (expQ.size() != 0) begin
				e = expQ.pop_front();
				checks++;
				assert (readRsp.data == e.data) else begin
					$display("Mismatch readRsp.data at addr 0x%h: got 0x%h expected 0x%h",
						e.addr, readRsp.data, e.data);
					errors++;
				end
				assert (cycles - e.cycle == 4) else begin
					$display("read response came %0d cycles after its strobe instead of 4",
						cycles - e.cycle);
					errors++;
				end
			end
		end
	end

	initial begin
		rst = 1'b0;
		start = 1'b0;
		mode = seqPkg::FILL_CHECK;
		speed = 2'd0;
		hostCmd = '0;
		repeat (3) @(negedge CLK);
		rst = 1'b1;
		expectValue("status.phase", int'(status.phase), int'(seqPkg::IDLE));
		expectValue("status.busy", int'(status.busy), 0);
		expectValue("status.done", int'(status.done), 0);
		expectValue("readRsp.valid", int'(readRsp.valid), 0);

		startRun(seqPkg::FILL_CHECK, 2'd0);
		finishRun(seqPkg::FILL_CHECK);
		repeat (8) begin
			hostAccess(1'b0, randomAddr(0, `FILL_COUNT), '0, 1'b1);
		end

		// three distinct tested words get data that breaks the pattern
		foreach (badAddr[i]) begin
			do begin
				badAddr[i] = randomAddr(0, `FILL_COUNT);
			end while (corrupted[badAddr[i]]);
			do begin
				badData = randomWord();
			end while (badData == expectedWord(badAddr[i]));
			hostAccess(1'b1, badAddr[i], badData, 1'b1);
			hostAccess(1'b0, badAddr[i], '0, 1'b1);
		end
		startRun(seqPkg::CHECK_ONLY, 2'd0);
		finishRun(seqPkg::CHECK_ONLY);

		startRun(seqPkg::FILL_CHECK, 2'd1);
		finishRun(seqPkg::FILL_CHECK);
		hostAccess(1'b0, badAddr[0], '0, 1'b1);

		hiAddr = randomAddr(`FILL_COUNT, (1 << `ADDR_W) - `FILL_COUNT);
		hiData = randomWord();
		hostAccess(1'b1, hiAddr, hiData, 1'b1);
		hostAccess(1'b0, hiAddr, '0, 1'b1);
		startRun(seqPkg::FILL_CHECK, 2'd0);
		repeat (8) @(negedge CLK);
		// the run owns the memory, so these must be dropped
		hostAccess(1'b1, hiAddr, ~hiData, 1'b0);
		hostAccess(1'b0, hiAddr, '0, 1'b0);
		mode = seqPkg::CHECK_ONLY;
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		// still filling, the second start is dropped
		expectValue("status.phase", int'(status.phase), int'(seqPkg::FILL));
		finishRun(seqPkg::FILL_CHECK);
		hostAccess(1'b0, hiAddr, '0, 1'b1);
		drainReads();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sramSubsystem.f */
+incdir+logic
logic/memPkg.sv
logic/seqPkg.sv
logic/sramArray.sv
logic/memAddrReg.sv
logic/memDataReg.sv
logic/stepTimer.sv
logic/fillCheckSeq.sv
logic/sramSubsystem.sv
verif/sramSubsystem_chk.sv
verif/sramSubsystemTb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module sramSubsystemTb -f sramSubsystem.f
if ! ./obj_dir/VsramSubsystemTb > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
